/* common/bus_arb_pkg.sv */
// Bus arbiter shared definitions
`default_nettype none

package bus_arb_pkg;

    // ##########################################################################
    // sizes
    localparam int num_masters     = 4;
    localparam int num_slaves      = 4;
    localparam int bid_width       = 4;
    localparam int credit_width    = 10;
    localparam int slave_sel_lsb   = 12;
    localparam int slave_sel_width = 4;

    typedef logic [bid_width-1:0]              bid_t;
    typedef logic [credit_width-1:0]           credit_t;
    typedef logic [31:0]                       addr_t;
    typedef logic [31:0]                       data_t;
    typedef logic [num_masters-1:0]            master_vec_t;
    typedef logic [$clog2(num_masters)-1:0]    master_idx_t;
    typedef bid_t    [num_masters-1:0]         bid_arr_t;
    typedef credit_t [num_masters-1:0]         credit_arr_t;

    // ##########################################################################
    // credit scheme
    localparam credit_t credit_init   = 10'd750;
    localparam credit_t credit_refill = 10'd750;
    localparam credit_t credit_max    = 10'd900;  // balances never refill above this
    localparam credit_t credit_floor  = 10'd1;

    localparam int refill_period = 400;  // timer counts 0..refill_period inclusive
    localparam int starve_limit  = 58;

endpackage

`default_nettype wire

/* common/arb_if.sv */
// Arbiter internal signal group
`timescale 1ns/1ps
`default_nettype none

interface arb_if;

    bus_arb_pkg::bid_arr_t    bid;      // raw bids from the masters
    bus_arb_pkg::master_vec_t grant;    // registered, one-hot or zero
    bus_arb_pkg::credit_arr_t balance;
    bus_arb_pkg::master_vec_t urgent;   // high while a master has waited too long

    modport arbiter (input bid, input balance, input urgent, output grant);

    modport bank (input bid, input grant, output balance);

    modport guard (input bid, input grant, output urgent);

endinterface

`default_nettype wire

/* common/bus_xfer_if.sv */
// Single transfer path
`timescale 1ns/1ps
`default_nettype none

interface bus_xfer_if;

    logic                rw;     // 1 for write
    bus_arb_pkg::addr_t  addr;
    bus_arb_pkg::data_t  wdata;
    bus_arb_pkg::data_t  rdata;

    modport initiator (output rw, output addr, output wdata, input rdata);

    modport target (input rw, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

/* arbiter/grant_arbiter.sv */
// Bid based grant arbiter
`timescale 1ns/1ps
`default_nettype none

module grant_arbiter (
    input  wire    clk,
    input  wire    rst,
    arb_if.arbiter arb
);

    bus_arb_pkg::master_vec_t eligible;
    bus_arb_pkg::master_vec_t top_bid;    // eligible and bidding the maximum
    bus_arb_pkg::master_vec_t decision;
    bus_arb_pkg::bid_t        max_bid;
    bus_arb_pkg::master_idx_t last_owner;
    bus_arb_pkg::master_idx_t idx;
    bus_arb_pkg::master_idx_t win_idx;
    logic                     found;

    // ##########################################################################
    // eligibility and the highest eligible bid
    always_comb begin
        max_bid = '0;
        for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
            eligible[i] = (arb.bid[i] != '0) &&
                          (arb.balance[i] >= bus_arb_pkg::credit_t'(arb.bid[i]));
            if (eligible[i] && (arb.bid[i] > max_bid)) begin
                max_bid = arb.bid[i];
            end
        end
        for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
            top_bid[i] = eligible[i] && (arb.bid[i] == max_bid);
        end
    end

    // ##########################################################################
    // urgent masters go first, lowest index wins among them
    always_comb begin
        decision = '0;
        found    = 1'b0;
        idx      = last_owner;
        win_idx  = last_owner;
        if (|arb.urgent) begin
            for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
                if (!found && arb.urgent[i]) begin
                    decision[i] = 1'b1;
                    win_idx     = bus_arb_pkg::master_idx_t'(i);
                    found       = 1'b1;
                end
            end
        end else begin
            // round-robin scan that begins just after the last owner
            for (int k = 0; k < bus_arb_pkg::num_masters; k++) begin
                idx = last_owner + bus_arb_pkg::master_idx_t'(k + 1);  // wraps naturally
                if (!found && top_bid[idx]) begin
                    decision[idx] = 1'b1;
                    win_idx       = idx;
                    found         = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arb.grant  <= '0;
            last_owner <= bus_arb_pkg::master_idx_t'(bus_arb_pkg::num_masters - 1);
        end else begin
            arb.grant <= decision;
            if (|decision) begin
                last_owner <= win_idx;  // tracks whoever holds the new grant
            end
        end
    end

endmodule

`default_nettype wire

/* arbiter/credit_bank.sv */
// Credit balances and refill timer
`timescale 1ns/1ps
`default_nettype none

module credit_bank (
    input  wire clk,
    input  wire rst,
    arb_if.bank arb
);

    logic [$clog2(bus_arb_pkg::refill_period + 1)-1:0] refill_timer;
    logic                                              refill_now;
    logic [bus_arb_pkg::credit_width:0]                sum   [bus_arb_pkg::num_masters];
    logic [bus_arb_pkg::credit_width:0]                need  [bus_arb_pkg::num_masters];
    bus_arb_pkg::credit_arr_t                          refilled;
    bus_arb_pkg::credit_arr_t                          charged;

    assign refill_now = (refill_timer == bus_arb_pkg::refill_period);

    always_comb begin
        for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
            sum[i]      = {1'b0, arb.balance[i]} + {1'b0, bus_arb_pkg::credit_refill};
            refilled[i] = (sum[i] > {1'b0, bus_arb_pkg::credit_max}) ?
                          bus_arb_pkg::credit_max : bus_arb_pkg::credit_t'(sum[i]);
            // charging must leave at least the floor, so compare before subtracting
            need[i]    = {1'b0, bus_arb_pkg::credit_t'(arb.bid[i])} +
                         {1'b0, bus_arb_pkg::credit_floor};
            charged[i] = ({1'b0, arb.balance[i]} >= need[i]) ?
                         arb.balance[i] - bus_arb_pkg::credit_t'(arb.bid[i]) :
                         bus_arb_pkg::credit_floor;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            refill_timer <= '0;
            arb.balance  <= {bus_arb_pkg::num_masters{bus_arb_pkg::credit_init}};
        end else begin
            refill_timer <= refill_now ? '0 : refill_timer + 1'b1;
            for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
                if (refill_now) begin
                    arb.balance[i] <= refilled[i];  // refill wins over a charge
                end else if (arb.grant[i]) begin
                    arb.balance[i] <= charged[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* arbiter/starvation_guard.sv */
// Starvation wait counters
`timescale 1ns/1ps
`default_nettype none

module starvation_guard (
    input  wire  clk,
    input  wire  rst,
    arb_if.guard arb
);

    logic [$clog2(bus_arb_pkg::starve_limit + 1)-1:0] wait_cnt [bus_arb_pkg::num_masters];

    // a master counts only while it bids and is not the owner
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
                wait_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
                if ((arb.bid[i] != '0) && !arb.grant[i]) begin
                    if (wait_cnt[i] != bus_arb_pkg::starve_limit) begin
                        wait_cnt[i] <= wait_cnt[i] + 1'b1;  // saturates at the limit
                    end
                end else begin
                    wait_cnt[i] <= '0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
            arb.urgent[i] = (wait_cnt[i] == bus_arb_pkg::starve_limit);
        end
    end

endmodule

`default_nettype wire

/* src/bus_crossbar.sv */
// Owner to slave crossbar
`timescale 1ns/1ps
`default_nettype none

module bus_crossbar (
    input  wire bus_arb_pkg::master_vec_t grant,
    bus_xfer_if.target                    mst [bus_arb_pkg::num_masters],
    bus_xfer_if.initiator                 slv [bus_arb_pkg::num_slaves],
    output bus_arb_pkg::master_vec_t      sel
);

    logic               mst_rw    [bus_arb_pkg::num_masters];
    bus_arb_pkg::addr_t mst_addr  [bus_arb_pkg::num_masters];
    bus_arb_pkg::data_t mst_wdata [bus_arb_pkg::num_masters];
    bus_arb_pkg::data_t slv_rdata [bus_arb_pkg::num_slaves];

    logic                                     own_rw;
    bus_arb_pkg::addr_t                       own_addr;
    bus_arb_pkg::data_t                       own_wdata;
    bus_arb_pkg::data_t                       sel_rdata;
    logic [bus_arb_pkg::slave_sel_width-1:0]  field;

    for (genvar i = 0; i < bus_arb_pkg::num_masters; i++) begin : g_mst
        assign mst_rw[i]    = mst[i].rw;
        assign mst_addr[i]  = mst[i].addr;
        assign mst_wdata[i] = mst[i].wdata;
        assign mst[i].rdata = grant[i] ? sel_rdata : '0;  // non-owners read zero
    end

    for (genvar s = 0; s < bus_arb_pkg::num_slaves; s++) begin : g_slv
        assign slv_rdata[s] = slv[s].rdata;
        assign slv[s].rw    = sel[s] & own_rw;
        assign slv[s].addr  = sel[s] ? own_addr : '0;
        assign slv[s].wdata = sel[s] ? own_wdata : '0;
    end

    // ##########################################################################
    // grant is one-hot, so OR-ing the gated masters picks the owner
    always_comb begin
        own_rw    = 1'b0;
        own_addr  = '0;
        own_wdata = '0;
        for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
            if (grant[i]) begin
                own_rw    = own_rw | mst_rw[i];
                own_addr  = own_addr | mst_addr[i];
                own_wdata = own_wdata | mst_wdata[i];
            end
        end
        field = own_addr[bus_arb_pkg::slave_sel_lsb +: bus_arb_pkg::slave_sel_width];
        sel       = '0;
        sel_rdata = '0;
        for (int s = 0; s < bus_arb_pkg::num_slaves; s++) begin
            // field values past the last slave decode to nothing
            sel[s] = (|grant) && (field == s);
            if (sel[s]) begin
                sel_rdata = slv_rdata[s];
            end
        end
    end

endmodule

`default_nettype wire

/* src/bus_arbiter_top.sv */
// Bus arbiter top level
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter_top (
    input  wire                                                     clk,
    input  wire                                                     rst,
    input  wire bus_arb_pkg::bid_arr_t                              m_bid,
    input  wire bus_arb_pkg::master_vec_t                           m_rw,
    input  wire bus_arb_pkg::addr_t [bus_arb_pkg::num_masters-1:0]  m_addr,
    input  wire bus_arb_pkg::data_t [bus_arb_pkg::num_masters-1:0]  m_wdata,
    input  wire bus_arb_pkg::data_t [bus_arb_pkg::num_slaves-1:0]   s_rdata,
    output bus_arb_pkg::master_vec_t                                m_grant,
    output bus_arb_pkg::data_t [bus_arb_pkg::num_masters-1:0]       m_rdata,
    output bus_arb_pkg::master_vec_t                                s_sel,
    output bus_arb_pkg::master_vec_t                                s_rw,
    output bus_arb_pkg::addr_t [bus_arb_pkg::num_slaves-1:0]        s_addr,
    output bus_arb_pkg::data_t [bus_arb_pkg::num_slaves-1:0]        s_wdata
);

    arb_if      arb ();
    bus_xfer_if mst_bus [bus_arb_pkg::num_masters] ();
    bus_xfer_if slv_bus [bus_arb_pkg::num_slaves] ();

    assign arb.bid = m_bid;
    assign m_grant = arb.grant;

    // ##########################################################################
    // port mapping onto the transfer paths
    for (genvar i = 0; i < bus_arb_pkg::num_masters; i++) begin : g_mst_port
        assign mst_bus[i].rw    = m_rw[i];
        assign mst_bus[i].addr  = m_addr[i];
        assign mst_bus[i].wdata = m_wdata[i];
        assign m_rdata[i]       = mst_bus[i].rdata;
    end

    for (genvar s = 0; s < bus_arb_pkg::num_slaves; s++) begin : g_slv_port
        assign s_rw[s]          = slv_bus[s].rw;
        assign s_addr[s]        = slv_bus[s].addr;
        assign s_wdata[s]       = slv_bus[s].wdata;
        assign slv_bus[s].rdata = s_rdata[s];
    end

    grant_arbiter u_grant_arbiter (
        .clk (clk),
        .rst (rst),
        .arb (arb.arbiter)
    );

    credit_bank u_credit_bank (
        .clk (clk),
        .rst (rst),
        .arb (arb.bank)
    );

    starvation_guard u_starvation_guard (
        .clk (clk),
        .rst (rst),
        .arb (arb.guard)
    );

    // routing follows the registered grant within the same cycle
    bus_crossbar u_bus_crossbar (
        .grant (arb.grant),
        .mst   (mst_bus),
        .slv   (slv_bus),
        .sel   (s_sel)
    );

endmodule

`default_nettype wire

/* testbench/bus_arbiter_properties.sv */
// Grant and select properties
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter_properties (
    input wire                           clk,
    input wire                           rst,
    input wire bus_arb_pkg::master_vec_t grant,
    input wire bus_arb_pkg::master_vec_t sel
);

    int unsigned fail_count = 0;  // read by the testbench at the end of the run

    grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else begin
            $error("grant has more than one bit set: %b", grant);
            fail_count++;
        end

    sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
        else begin
            $error("slave select has more than one bit set: %b", sel);
            fail_count++;
        end

    // no owner means no slave may be selected
    sel_needs_grant: assert property (@(posedge clk) disable iff (rst)
                                      (grant == '0) |-> (sel == '0))
        else begin
            $error("slave select %b is active without a grant", sel);
            fail_count++;
        end

endmodule

bind bus_arbiter_top bus_arbiter_properties props (
    .clk   (clk),
    .rst   (rst),
    .grant (m_grant),
    .sel   (s_sel)
);

`default_nettype wire

/* testbench/bus_arbiter_tb.sv */
// Bus arbiter testbench
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter_tb;

    localparam int row_words  = 13;    // four bids, four slave fields, four rw bits, count
    localparam int max_rows   = 16;
    localparam int max_cycles = 2000;

    logic                                               clk;
    logic                                               rst;
    bus_arb_pkg::bid_arr_t                              m_bid;
    bus_arb_pkg::master_vec_t                           m_rw;
    bus_arb_pkg::addr_t [bus_arb_pkg::num_masters-1:0]  m_addr;
    bus_arb_pkg::data_t [bus_arb_pkg::num_masters-1:0]  m_wdata;
    bus_arb_pkg::data_t [bus_arb_pkg::num_slaves-1:0]   s_rdata;
    bus_arb_pkg::master_vec_t                           m_grant;
    bus_arb_pkg::data_t [bus_arb_pkg::num_masters-1:0]  m_rdata;
    bus_arb_pkg::master_vec_t                           s_sel;
    bus_arb_pkg::master_vec_t                           s_rw;
    bus_arb_pkg::addr_t [bus_arb_pkg::num_slaves-1:0]   s_addr;
    bus_arb_pkg::data_t [bus_arb_pkg::num_slaves-1:0]   s_wdata;

    logic [15:0] rows [row_words*max_rows];
    logic [31:0] lfsr;
    int          cycle_no;

    // reference model state that mirrors the registers of the DUT
    int                       ref_bal  [bus_arb_pkg::num_masters];
    int                       ref_wait [bus_arb_pkg::num_masters];
    int                       ref_timer;
    int                       ref_last;
    bus_arb_pkg::master_vec_t exp_grant;

    bus_arbiter_top dut (
        .clk     (clk),
        .rst     (rst),
        .m_bid   (m_bid),
        .m_rw    (m_rw),
        .m_addr  (m_addr),
        .m_wdata (m_wdata),
        .s_rdata (s_rdata),
        .m_grant (m_grant),
        .m_rdata (m_rdata),
        .s_sel   (s_sel),
        .s_rw    (s_rw),
        .s_addr  (s_addr),
        .s_wdata (s_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ##########################################################################
    // random data takes one LFSR step per bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_step(lfsr);
            w    = {w[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic drive_inputs(input int r);
        logic [31:0] w;
        for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
            m_bid[i] = rows[r*row_words + i][3:0];
            m_rw[i]  = rows[r*row_words + 8 + i][0];
            take_word(w);
            w[bus_arb_pkg::slave_sel_lsb +: bus_arb_pkg::slave_sel_width] =
                rows[r*row_words + 4 + i][3:0];  // slave field comes from the file
            m_addr[i] = w;
            take_word(w);
            m_wdata[i] = w;
        end
        for (int s = 0; s < bus_arb_pkg::num_slaves; s++) begin
            take_word(w);
            s_rdata[s] = w;
        end
    endtask

    // ##########################################################################
    // the reference model steps once per clock edge with the inputs the DUT samples
    task automatic model_step();
        bus_arb_pkg::master_vec_t decision;
        int win;
        int max_bid;
        int idx;
        decision = '0;
        win      = ref_last;
        max_bid  = 0;
        for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
            if (decision == '0 && ref_wait[i] == bus_arb_pkg::starve_limit) begin
                decision[i] = 1'b1;
                win         = i;
            end
        end
        if (decision == '0) begin
            for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
                if (m_bid[i] != 0 && ref_bal[i] >= int'(m_bid[i]) &&
                    int'(m_bid[i]) > max_bid) begin
                    max_bid = m_bid[i];
                end
            end
            for (int k = 1; k <= bus_arb_pkg::num_masters; k++) begin
                idx = (ref_last + k) % bus_arb_pkg::num_masters;  // search starts after last owner
                if (decision == '0 && max_bid != 0 && int'(m_bid[idx]) == max_bid &&
                    ref_bal[idx] >= max_bid) begin
                    decision[idx] = 1'b1;
                    win           = idx;
                end
            end
        end
        for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
            if (ref_timer == bus_arb_pkg::refill_period) begin
                ref_bal[i] = ref_bal[i] + int'(bus_arb_pkg::credit_refill);
                if (ref_bal[i] > int'(bus_arb_pkg::credit_max)) begin
                    ref_bal[i] = bus_arb_pkg::credit_max;
                end
            end else if (exp_grant[i]) begin
                ref_bal[i] = ref_bal[i] - int'(m_bid[i]);
                if (ref_bal[i] < int'(bus_arb_pkg::credit_floor)) begin
                    ref_bal[i] = bus_arb_pkg::credit_floor;
                end
            end
            if (m_bid[i] != 0 && !exp_grant[i]) begin
                if (ref_wait[i] < bus_arb_pkg::starve_limit) ref_wait[i] = ref_wait[i] + 1;
            end else begin
                ref_wait[i] = 0;
            end
        end
        ref_timer = (ref_timer == bus_arb_pkg::refill_period) ? 0 : ref_timer + 1;
        if (decision != '0) ref_last = win;
        exp_grant = decision;
    endtask

    task automatic check_routing();
        int                       owner;
        logic [3:0]               field;
        bus_arb_pkg::master_vec_t exp_sel;
        logic                     own_rw;
        logic [31:0]              own_addr;
        logic [31:0]              own_wdata;
        logic [31:0]              own_rdata;
        owner     = -1;
        field     = '0;
        exp_sel   = '0;
        own_rw    = 1'b0;
        own_addr  = '0;
        own_wdata = '0;
        own_rdata = '0;
        for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
            if (exp_grant[i]) owner = i;
        end
        if (owner >= 0) begin
            own_rw    = m_rw[owner];
            own_addr  = m_addr[owner];
            own_wdata = m_wdata[owner];
            field     = own_addr[bus_arb_pkg::slave_sel_lsb +: bus_arb_pkg::slave_sel_width];
            if (field < bus_arb_pkg::num_slaves) begin
                exp_sel[field] = 1'b1;
                own_rdata      = s_rdata[field];
            end
        end
        check_value("s_sel", s_sel, exp_sel);
        for (int s = 0; s < bus_arb_pkg::num_slaves; s++) begin
            check_value($sformatf("s_rw[%0d]", s), s_rw[s], exp_sel[s] ? own_rw : 1'b0);
            check_value($sformatf("s_addr[%0d]", s), s_addr[s], exp_sel[s] ? own_addr : '0);
            check_value($sformatf("s_wdata[%0d]", s), s_wdata[s], exp_sel[s] ? own_wdata : '0);
        end
        for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
            check_value($sformatf("m_rdata[%0d]", i), m_rdata[i], (i == owner) ? own_rdata : '0);
        end
    endtask

    // ##########################################################################
    // main sequence
    initial begin
        int count;
        lfsr      = 32'h446f;
        rst       = 1'b1;
        m_bid     = '0;
        m_rw      = '0;
        m_addr    = '0;
        m_wdata   = '0;
        s_rdata   = '0;
        cycle_no  = 0;
        ref_timer = 0;
        ref_last  = bus_arb_pkg::num_masters - 1;
        exp_grant = '0;
        for (int i = 0; i < bus_arb_pkg::num_masters; i++) begin
            ref_bal[i]  = bus_arb_pkg::credit_init;
            ref_wait[i] = 0;
        end
        $readmemh("testbench/bus_arbiter_testdata.txt", rows);
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        for (int r = 0; r < max_rows; r++) begin
            count = rows[r*row_words + 12];
            if (count == 0) break;  // all-zero row ends the data
            for (int c = 0; c < count; c++) begin
                drive_inputs(r);
                #1;
                check_value("m_grant", m_grant, exp_grant);
                check_routing();
                model_step();
                cycle_no++;
                if (cycle_no > max_cycles) begin
                    $display("the run went past %0d cycles without reaching the end", max_cycles);
                    $display("Errors found");
                    $fatal(1, "cycle limit reached");
                end
                @(posedge clk);
                #2;
            end
        end
        if (dut.props.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("%0d grant or select assertions failed", dut.props.fail_count);
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/bus_arbiter_testdata.txt */
// columns: bid0 bid1 bid2 bid3, slave field of master 0..3, rw of master 0..3, cycles (hex)
// a row of zeros ends the data
0 0 0 0   0 0 0 0   0 0 0 0   3
0 6 0 0   0 1 2 3   0 1 0 0   4
// distinct bids until master 0 runs out of credit
f e 0 0   0 1 2 3   1 0 0 0   3c
// equal top bids rotate
0 9 9 9   0 2 3 1   0 1 1 0   10
// steady 10 against 5 starves master 3
0 0 a 5   0 0 3 2   0 0 1 0   50
// master 0 waits for the refill
f 0 0 0   1 0 0 0   1 0 0 0   100
2 3 4 1   3 0 f 2   1 0 1 1   14
0 0 0 7   0 0 0 4   0 0 0 1   4
0 0 0 0   0 0 0 0   0 0 0 0   2
0 0 0 0   0 0 0 0   0 0 0 0   0

/* bus_arbiter_top.f */
common/bus_arb_pkg.sv
common/arb_if.sv
common/bus_xfer_if.sv
arbiter/grant_arbiter.sv
arbiter/credit_bank.sv
arbiter/starvation_guard.sv
src/bus_crossbar.sv
src/bus_arbiter_top.sv
testbench/bus_arbiter_properties.sv
testbench/bus_arbiter_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the bus arbiter testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
( verilator --binary --timing --assert -Wno-fatal --top-module bus_arbiter_tb \
    -f bus_arbiter_top.f --Mdir build -o sim_bus_arbiter \
    && ./build/sim_bus_arbiter ) > sim.log 2>&1
grep -qx "No errors" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }
